/* rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// instruction buffer entries. Upstream starts with this many credits.
`define RV_IBUF_DEPTH 4

// result buffer entries.
`define RV_RBUF_DEPTH 4

// credits the slice holds toward the consumer after reset.
`define RV_OUT_CREDITS 2

`endif

/* rv_pkg.sv */
package rv_pkg;

    // values follow the RV32I funct3 field so decode can cast directly.
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rs1  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_e;

    typedef enum logic {
        src2_rs2 = 1'b0,
        src2_imm = 1'b1
    } src2_e;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
    } fetch_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        rd_write;
        alu_op_e     alu_op;
        logic        sub_sra;
        src1_e       src1;
        src2_e       src2;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
    } decoded_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        rd_write;
        logic [31:0] pc;
        logic [31:0] result;
    } exec_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] value;
    } result_t;

endpackage

/* rv_credit_fifo.sv */
`timescale 1ns/1ps

module rv_credit_fifo #(
    parameter type T = logic [31:0],
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic empty,
    output logic full
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    assign empty    = (count == '0);
    assign full     = (count == CW'(DEPTH));
    assign pop_data = mem[rd_ptr]; // head is visible before the pop.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a push into a full buffer means the sender overspent its credits.
    assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("credit fifo pushed while full");

    assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("credit fifo popped while empty");

endmodule

/* rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_e op,
    input  logic            sub_sra,
    input  rv_pkg::src1_e   src1,
    input  rv_pkg::src2_e   src2,
    input  logic [31:0]     pc,
    input  logic [31:0]     rs1_value,
    input  logic [31:0]     rs2_value,
    input  logic [31:0]     imm,
    output logic [31:0]     result
);
    logic [31:0] op1;
    logic [31:0] op2;
    logic [4:0]  shamt;

    always_comb begin
        case (src1)
            rv_pkg::src1_rs1: op1 = rs1_value;
            rv_pkg::src1_pc:  op1 = pc;
            default:          op1 = '0;
        endcase
    end

    assign op2   = (src2 == rv_pkg::src2_imm) ? imm : rs2_value;
    assign shamt = op2[4:0];

    always_comb begin
        case (op)
            rv_pkg::alu_add:  result = sub_sra ? op1 - op2 : op1 + op2;
            rv_pkg::alu_sll:  result = op1 << shamt;
            rv_pkg::alu_slt:  result = {31'd0, $signed(op1) < $signed(op2)};
            rv_pkg::alu_sltu: result = {31'd0, op1 < op2};
            rv_pkg::alu_xor:  result = op1 ^ op2;
            rv_pkg::alu_srl: begin
                if (sub_sra) begin
                    result = $unsigned($signed(op1) >>> shamt); // sign fills from the top.
                end else begin
                    result = op1 >> shamt;
                end
            end
            rv_pkg::alu_or:   result = op1 | op2;
            rv_pkg::alu_and:  result = op1 & op2;
            default:          result = '0;
        endcase
    end

endmodule

/* rv_decode.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_decode (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  rv_pkg::fetch_t   in_data,
    output logic             in_credit,
    input  logic             stall,
    output logic [4:0]       rs1_addr,
    output logic [4:0]       rs2_addr,
    input  logic [31:0]      rs1_value,
    input  logic [31:0]      rs2_value,
    output rv_pkg::decoded_t dec
);
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    rv_pkg::fetch_t   head;
    rv_pkg::decoded_t dec_next;
    logic             pop;
    logic             empty;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;

    rv_credit_fifo #(
        .T     (rv_pkg::fetch_t),
        .DEPTH (`RV_IBUF_DEPTH)
    ) u_ibuf (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (in_data),
        .pop       (pop),
        .pop_data  (head),
        .empty     (empty),
        .full      ()
    );

    assign pop       = !empty && !stall;
    assign in_credit = pop; // the slot frees up as the entry leaves.

    assign opcode   = head.instr[6:0];
    assign funct3   = head.instr[14:12];
    assign funct7   = head.instr[31:25];
    assign rs1_addr = head.instr[19:15];
    assign rs2_addr = head.instr[24:20];

    always_comb begin
        dec_next           = '0;
        dec_next.valid     = pop;
        dec_next.rd        = head.instr[11:7];
        dec_next.pc        = head.pc;
        dec_next.rs1_value = rs1_value;
        dec_next.rs2_value = rs2_value;
        dec_next.alu_op    = rv_pkg::alu_add;
        dec_next.src1      = rv_pkg::src1_zero;
        dec_next.src2      = rv_pkg::src2_imm;
        case (opcode)
            opc_op: begin
                dec_next.rs1      = rs1_addr;
                dec_next.rs2      = rs2_addr;
                dec_next.rd_write = 1'b1;
                dec_next.alu_op   = rv_pkg::alu_op_e'(funct3);
                dec_next.sub_sra  = funct7[5];
                dec_next.src1     = rv_pkg::src1_rs1;
                dec_next.src2     = rv_pkg::src2_rs2;
            end
            opc_op_imm: begin
                dec_next.rs1      = rs1_addr;
                dec_next.rd_write = 1'b1;
                dec_next.alu_op   = rv_pkg::alu_op_e'(funct3);
                dec_next.sub_sra  = (funct3 == 3'b101) && funct7[5]; // only srai uses it.
                dec_next.src1     = rv_pkg::src1_rs1;
                dec_next.imm      = {{20{head.instr[31]}}, head.instr[31:20]};
            end
            opc_lui: begin
                dec_next.rd_write = 1'b1;
                dec_next.imm      = {head.instr[31:12], 12'd0};
            end
            opc_auipc: begin
                dec_next.rd_write = 1'b1;
                dec_next.src1     = rv_pkg::src1_pc;
                dec_next.imm      = {head.instr[31:12], 12'd0};
            end
            default: dec_next.rd_write = 1'b0; // retires as a no-op.
        endcase
        dec_next.rd_write = dec_next.rd_write && (dec_next.rd != 5'd0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec <= '0;
        end else if (!stall) begin
            dec <= dec_next;
        end
    end

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  rv_pkg::decoded_t dec,
    output rv_pkg::exec_t    ex
);
    logic          ex_writes;
    logic          fwd_rs1;
    logic          fwd_rs2;
    logic [31:0]   rs1_value;
    logic [31:0]   rs2_value;
    logic [31:0]   result;
    rv_pkg::exec_t ex_next;

    // the older instruction in ex has not reached the register file yet.
    assign ex_writes = ex.valid && ex.rd_write;
    assign fwd_rs1   = ex_writes && (ex.rd == dec.rs1) && (dec.rs1 != 5'd0);
    assign fwd_rs2   = ex_writes && (ex.rd == dec.rs2) && (dec.rs2 != 5'd0);
    assign rs1_value = fwd_rs1 ? ex.result : dec.rs1_value;
    assign rs2_value = fwd_rs2 ? ex.result : dec.rs2_value;

    rv_alu u_alu (
        .op        (dec.alu_op),
        .sub_sra   (dec.sub_sra),
        .src1      (dec.src1),
        .src2      (dec.src2),
        .pc        (dec.pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .imm       (dec.imm),
        .result    (result)
    );

    always_comb begin
        ex_next.valid    = dec.valid;
        ex_next.rd       = dec.rd;
        ex_next.rd_write = dec.valid && dec.rd_write;
        ex_next.pc       = dec.pc;
        ex_next.result   = result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex <= '0;
        end else if (!stall) begin
            ex <= ex_next;
        end
    end

    // decode never flags x0 as written, so nothing can forward onto x0.
    assert property (@(posedge clk) disable iff (!rst_n)
        ex_writes |-> (ex.rd != 5'd0))
        else $error("forwarding source targets register x0");

endmodule

/* rv_writeback.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_writeback (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::exec_t   ex,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [31:0]     rs1_value,
    output logic [31:0]     rs2_value,
    output logic            stall,
    output logic            out_valid,
    output rv_pkg::result_t out_data,
    input  logic            out_credit
);
    localparam int CW = $clog2(`RV_OUT_CREDITS + 1) + 1;

    logic [31:0]     regs [31:1];
    logic            push;
    logic            rf_write;
    logic            rbuf_empty;
    logic            rbuf_full;
    logic [CW-1:0]   credit_cnt;
    rv_pkg::result_t wb_result;

    assign stall    = rbuf_full && ex.valid;
    assign push     = ex.valid && !rbuf_full;
    assign rf_write = push && ex.rd_write;

    assign wb_result.rd    = ex.rd_write ? ex.rd : 5'd0; // no-ops retire with rd zero.
    assign wb_result.pc    = ex.pc;
    assign wb_result.value = ex.result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write) begin
            regs[ex.rd] <= ex.result;
        end
    end

    // the value being written this cycle wins over the stored one.
    always_comb begin
        if (rs1_addr == 5'd0) begin
            rs1_value = '0;
        end else if (rf_write && (ex.rd == rs1_addr)) begin
            rs1_value = ex.result;
        end else begin
            rs1_value = regs[rs1_addr];
        end
        if (rs2_addr == 5'd0) begin
            rs2_value = '0;
        end else if (rf_write && (ex.rd == rs2_addr)) begin
            rs2_value = ex.result;
        end else begin
            rs2_value = regs[rs2_addr];
        end
    end

    rv_credit_fifo #(
        .T     (rv_pkg::result_t),
        .DEPTH (`RV_RBUF_DEPTH)
    ) u_rbuf (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (wb_result),
        .pop       (out_valid),
        .pop_data  (out_data),
        .empty     (rbuf_empty),
        .full      (rbuf_full)
    );

    assign out_valid = !rbuf_empty && (credit_cnt != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CW'(`RV_OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CW'(out_valid) + CW'(out_credit);
        end
    end

    // the consumer may only return credits it was actually given.
    assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= CW'(`RV_OUT_CREDITS))
        else $error("output credit counter above its reset value");

endmodule

/* rv_core_slice.sv */
`timescale 1ns/1ps

module rv_core_slice (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  rv_pkg::fetch_t  in_data,
    output logic            in_credit,
    output logic            out_valid,
    output rv_pkg::result_t out_data,
    input  logic            out_credit
);
    logic             stall;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [31:0]      rs1_value;
    logic [31:0]      rs2_value;
    rv_pkg::decoded_t dec;
    rv_pkg::exec_t    ex;

    rv_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_credit (in_credit),
        .stall     (stall),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .dec       (dec)
    );

    rv_execute u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .dec   (dec),
        .ex    (ex)
    );

    rv_writeback u_writeback (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex         (ex),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .stall      (stall),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

endmodule

/* tb_rv_core_slice.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_rv_core_slice;
    localparam int max_tests  = 64;
    localparam int wait_limit = 2000;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    rv_pkg::fetch_t  in_data;
    logic            in_credit;
    logic            out_valid;
    rv_pkg::result_t out_data;
    logic            out_credit;

    logic [31:0] vectors [0:3*max_tests-1];
    integer      seed;
    int          num_tests;
    int          sent;
    int          received;
    int          pass_count;
    int          fail_count;
    int          error_count;
    int          in_credits;    // input credits the source still holds.
    int          credit_pulses;
    int          out_credits;   // output credits the slice holds, as the sink counts them.
    int          unreturned;    // results taken but not yet credited back.
    bit          withheld_once;
    bit          timed_out;

    rv_core_slice u_rv_core_slice (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_result(input rv_pkg::result_t res);
        logic [31:0] exp_rd;
        logic [31:0] exp_value;
        int          errors;
        errors = 0;
        if (received >= num_tests) begin
            $display("[FAIL] %0t: extra result with pc %h after the last test", $time, res.pc);
            error_count++;
        end else begin
            exp_rd    = vectors[3*received+1];
            exp_value = vectors[3*received+2];
            if (res.pc != 32'(4 * received)) begin
                $display("[FAIL] %0t: test %0d retired pc %h, expected %h",
                         $time, received, res.pc, 32'(4 * received));
                errors++;
            end
            if (res.rd != exp_rd[4:0]) begin
                $display("[FAIL] %0t: test %0d retired rd x%0d, expected x%0d",
                         $time, received, res.rd, exp_rd[4:0]);
                errors++;
            end
            // rd zero marks an instruction that writes no register, so its value is free.
            if (exp_rd[4:0] != 5'd0 && res.value != exp_value) begin
                $display("[FAIL] %0t: test %0d value %h, expected %h",
                         $time, received, res.value, exp_value);
                errors++;
            end
            error_count += errors;
            if (errors == 0) begin
                pass_count++;
                $display("test %0d pc %h rd x%0d value %h ok", received, res.pc, res.rd, res.value);
            end else begin
                fail_count++;
                $display("test %0d finished with %0d errors", received, errors);
            end
        end
        received++;
    endtask

    // outputs only change after a rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_credit) begin
                credit_pulses++;
                in_credits++;
                if (in_credits > `RV_IBUF_DEPTH) begin
                    $display("[FAIL] %0t: source would hold %0d input credits, above %0d",
                             $time, in_credits, `RV_IBUF_DEPTH);
                    error_count++;
                end
            end
            if (out_valid) begin
                if (out_credits == 0) begin
                    $display("[FAIL] %0t: out_valid raised with no output credit left", $time);
                    error_count++;
                end
                out_credits--;
                unreturned++;
                check_result(out_data);
            end
        end
    end

    task automatic run_source();
        int waited;
        for (int i = 0; i < num_tests && !timed_out; i++) begin
            waited = 0;
            while (in_credits == 0 && waited < wait_limit && !timed_out) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
                waited++;
            end
            if (in_credits == 0) begin
                if (!timed_out) begin
                    $display("timeout: the source waited too long for an input credit");
                end
                timed_out = 1'b1;
            end else begin
                in_valid      = 1'b1;
                in_data.instr = vectors[3*i];
                in_data.pc    = 32'(4 * i); // pc follows the line order of the file.
                in_credits--;
                sent++;
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic run_sink();
        int cycles;
        int hold_left;
        cycles    = 0;
        hold_left = 0;
        while (!timed_out && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
            out_credit = 1'b0;
            if (!withheld_once && received >= 6) begin
                withheld_once = 1'b1;
                hold_left     = 24; // long enough to back the whole pipeline up.
            end
            if (hold_left > 0) begin
                hold_left--;
            end else if (unreturned > 0 && ($random(seed) & 3) != 0) begin
                out_credit = 1'b1;
                unreturned--;
                out_credits++;
            end
        end
        out_credit = 1'b0;
    endtask

    initial begin
        int cycles;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_data       = '0;
        out_credit    = 1'b0;
        seed          = 68822;
        sent          = 0;
        received      = 0;
        pass_count    = 0;
        fail_count    = 0;
        error_count   = 0;
        credit_pulses = 0;
        unreturned    = 0;
        withheld_once = 1'b0;
        timed_out     = 1'b0;
        in_credits    = `RV_IBUF_DEPTH;
        out_credits   = `RV_OUT_CREDITS;
        $readmemh("rv_tests.txt", vectors);
        num_tests = 0;
        while (num_tests < max_tests && !$isunknown(vectors[3*num_tests])) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("no test vectors could be read from rv_tests.txt");
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            run_source();
            run_sink();
        join_none
        cycles = 0;
        while (received < num_tests && !timed_out && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (received < num_tests && !timed_out) begin
            $display("timeout: only %0d of %0d results arrived", received, num_tests);
            timed_out = 1'b1;
        end
        repeat (10) @(posedge clk); // stray or repeated results would show up here.
        if (credit_pulses != sent || in_credits != `RV_IBUF_DEPTH) begin
            $display("[FAIL] %0t: %0d in_credit pulses for %0d instructions sent",
                     $time, credit_pulses, sent);
            error_count++;
        end
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, error_count);
        if (error_count == 0 && !timed_out && num_tests > 0 && pass_count == num_tests) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* rv_tests.txt */
// columns: instruction word, expected rd, expected value (all hex), pc is 4 * line index
// rd 00 retires without a register write and its value is not compared
00500093 01 00000005
FFD00113 02 FFFFFFFD
002081B3 03 00000002
40208233 04 00000008
401152B3 05 FFFFFFFF
00115333 06 07FFFFFF
0020B3B3 07 00000001
0020A433 08 00000000
0020C4B3 09 FFFFFFF8
0041E533 0A 0000000A
004175B3 0B 00000008
00309633 0C 00000014
123456B7 0D 12345000
00001717 0E 00001034
67868693 0D 12345678
4046D793 0F 01234567
FFF7C813 10 FEDCBA98
00708013 00 00000000
001008B3 11 00000005
FFE12913 12 00000001
0060B993 13 00000001
0FF87A13 14 00000098
700A6A93 15 00000798
01C09B13 16 50000000
00885B93 17 00FEDCBA
0000000F 00 00000000
01788C33 18 00FEDCBF

/* tb.f */
+incdir+.
rv_pkg.sv
rv_credit_fifo.sv
rv_alu.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_core_slice.sv
tb_rv_core_slice.sv
